// File: test/fix_vectors.txt
# type sender target heartbeat seq checksum
# type is one-hot: 1 logon, 2 heartbeat, 4 logout; heartbeat text is used by logon only
1 CLIENT BROKER 30 0001 012
2 CLIENT BROKER 30 0002 095
2 BROKER CLIENT 30 0003 096
4 CLIENT BROKER 30 0004 102
1 DESK01 EXCH 60 0005 063
2 DESK01 EXCH 60 0006 143
1 GATEWAY1 VENUE 120 0007 132
4 GATEWAY1 VENUE 120 0008 172
1 A XY 5 0009 084
2 XY A 5 0010 204
4 DESK01 EXCH 60 0011 144
1 BROKER GATEWAY1 30 0012 146

// File: src.f
+incdir+hdl
hdl/fix_pkg.sv
hdl/fix_field_sequencer.sv
hdl/fix_field_formatter.sv
hdl/fix_checksum_stage.sv
hdl/fix_credit_port.sv
hdl/fix_msg_builder.sv
test/fix_msg_builder_sva.sv
test/fix_msg_builder_tb.sv

// File: test/fix_msg_builder_tb.sv
// FIX message builder testbench
`timescale 1ns/1ps
`include "fix_settings.svh"

module fix_msg_builder_tb;
	import fix_pkg::*;

	localparam int WAIT_LIMIT = 400;

	logic      clk;
	logic      rst;
	logic      req_valid_i;
	fix_req_t  req_i;
	logic      req_ready_o;
	logic      beat_valid_o;
	fix_beat_t beat_o;
	logic      credit_return_i;

	fix_req_t  req_list[$];
	fix_beat_t exp_beats[$];
	string     exp_names[$];
	int        next_seq;
	// beats received and credits handed back so far
	int        beats_seen;
	int        credits_back;
	logic      stim_done;

	fix_msg_builder u_dut (
		.clk             (clk),
		.rst             (rst),
		.req_valid_i     (req_valid_i),
		.req_i           (req_i),
		.req_ready_o     (req_ready_o),
		.beat_valid_o    (beat_valid_o),
		.beat_o          (beat_o),
		.credit_return_i (credit_return_i)
	);

	always begin
		clk = 1'b0;
		#2;
		clk = 1'b1;
		#2;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Result: FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// stop on the first failure of the bound credit checker
	always @(negedge clk) begin
		assert (u_dut.u_credit_port.u_sva.fail_cnt == 0) else begin
			abort_run("an assertion in the credit port checker failed");
		end
	end

	// first character in byte 0, zero past the end
	function automatic fix_text_t to_text(input string s);
		fix_text_t t;
		t = '0;
		for (int i = 0; i < s.len() && i < `FIX_VAL_BYTES; i++) begin
			t[i*8 +: 8] = s[i];
		end
		return t;
	endfunction

	function automatic int text_sum(input string s);
		int acc;
		acc = 0;
		for (int i = 0; i < s.len(); i++) begin
			acc = acc + int'(s[i]);
		end
		return acc;
	endfunction

	function automatic fix_beat_t make_beat(input logic is_tag, input string s, input logic last);
		fix_beat_t b;
		fix_text_t t;
		t = to_text(s);
		b = '0;
		b.is_tag = is_tag;
		b.last = last;
		if (is_tag) begin
			b.payload.tag.len = 4'(s.len());
			b.payload.tag.text = t[`FIX_TAG_BYTES*8-1:0];
		end else begin
			b.payload.val.len = 4'(s.len());
			b.payload.val.text = t;
		end
		return b;
	endfunction

	task automatic push_field(input string name, input string tag, input string val,
			inout int sum);
		exp_beats.push_back(make_beat(1'b1, tag, 1'b0));
		exp_names.push_back({name, " tag ", tag});
		exp_beats.push_back(make_beat(1'b0, val, 1'b0));
		exp_names.push_back({name, " value of ", tag});
		sum = sum + text_sum(tag) + text_sum(val);
	endtask

	// reference beat list for one message, checked against the file columns
	task automatic expect_message(input int idx, input fix_msg_type_e t, input string snd,
			input string tgt, input string hbt, input string seq_f, input string chk_f);
		string name;
		string seq_txt;
		string chk_txt;
		string type_txt;
		int    sum;
		name = $sformatf("msg%0d", idx);
		seq_txt = $sformatf("%04d", next_seq);
		next_seq++;
		sum = 0;
		type_txt = "";
		case (t)
			MSG_LOGON:     type_txt = "A";
			MSG_HEARTBEAT: type_txt = "0";
			MSG_LOGOUT:    type_txt = "5";
			default:       abort_run($sformatf("unknown message type in vector %0d", idx));
		endcase
		assert (seq_txt == seq_f) else begin
			abort_run($sformatf("[ERROR] %s seq in file expected %s actual %s",
				name, seq_f, seq_txt));
		end
		push_field(name, "8", "FIX.4.2", sum);
		push_field(name, "34", seq_txt, sum);
		push_field(name, "35", type_txt, sum);
		push_field(name, "49", snd, sum);
		push_field(name, "56", tgt, sum);
		if (t == MSG_LOGON) begin
			push_field(name, "98", "0", sum);
			push_field(name, "108", hbt, sum);
		end
		// the checksum tag itself counts toward the sum
		exp_beats.push_back(make_beat(1'b1, "10", 1'b0));
		exp_names.push_back({name, " tag 10"});
		sum = sum + text_sum("10");
		chk_txt = $sformatf("%03d", sum % `FIX_CHKSUM_MOD);
		assert (chk_txt == chk_f) else begin
			abort_run($sformatf("[ERROR] %s checksum in file expected %s actual %s",
				name, chk_f, chk_txt));
		end
		exp_beats.push_back(make_beat(1'b0, chk_txt, 1'b1));
		exp_names.push_back({name, " value of 10"});
	endtask

	task automatic load_vectors();
		int       fd;
		int       n;
		string    tok;
		string    snd;
		string    tgt;
		string    hbt;
		string    seq_f;
		string    chk_f;
		string    line;
		fix_req_t r;
		next_seq = 1;
		fd = $fopen("test/fix_vectors.txt", "r");
		if (fd == 0) begin
			abort_run("could not open the vector file test/fix_vectors.txt");
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", tok);
			if (n == 1 && tok[0] == "#") begin
				n = $fgets(line, fd);
			end else if (n == 1) begin
				n = $fscanf(fd, "%s %s %s %s %s", snd, tgt, hbt, seq_f, chk_f);
				if (n != 5 || snd.len() > 8 || tgt.len() > 8 || hbt.len() > 8) begin
					abort_run("malformed line in the vector file");
				end
				r = '0;
				r.msg_type = fix_msg_type_e'(tok.atohex());
				r.sender = to_text(snd);
				r.sender_len = 4'(snd.len());
				r.target = to_text(tgt);
				r.target_len = 4'(tgt.len());
				r.hbt = to_text(hbt);
				r.hbt_len = 4'(hbt.len());
				req_list.push_back(r);
				expect_message(req_list.size(), r.msg_type, snd, tgt, hbt, seq_f, chk_f);
			end
		end
		$fclose(fd);
		if (req_list.size() == 0) begin
			abort_run("the vector file holds no requests");
		end
	endtask

	task automatic send_requests();
		int waited;
		foreach (req_list[i]) begin
			@(posedge clk);
			#1;
			req_valid_i = 1'b1;
			req_i = req_list[i];
			waited = 0;
			// ready is registered, so its negedge value holds at the next edge
			@(negedge clk);
			while (req_ready_o !== 1'b1) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					abort_run($sformatf("timed out waiting for req_ready_o, request %0d", i + 1));
				end
				@(negedge clk);
			end
			@(posedge clk);
			#1;
			req_valid_i = 1'b0;
		end
	endtask

	task automatic check_beats();
		int waited;
		int held;
		foreach (exp_beats[i]) begin
			waited = 0;
			@(negedge clk);
			while (beat_valid_o !== 1'b1) begin
				waited++;
				if (waited > WAIT_LIMIT) begin
					abort_run($sformatf("timed out waiting for beat %s", exp_names[i]));
				end
				@(negedge clk);
			end
			held = `FIX_TX_CREDITS - (beats_seen - credits_back);
			assert (held > 0) else begin
				abort_run($sformatf("beat %s came out while no credit was available",
					exp_names[i]));
			end
			beats_seen++;
			assert (beat_o === exp_beats[i]) else begin
				abort_run($sformatf("[ERROR] %s expected %h actual %h",
					exp_names[i], exp_beats[i], beat_o));
			end
		end
	endtask

	// random credit return, never more than was received
	task automatic return_credits();
		while (!stim_done) begin
			@(posedge clk);
			#1;
			credit_return_i = (beats_seen > credits_back) && ($urandom % 2 == 0);
			if (credit_return_i) begin
				credits_back++;
			end
		end
	endtask

	initial begin
		void'($urandom(32'he2b3e52d));
		rst = 1'b1;
		req_valid_i = 1'b0;
		req_i = '0;
		credit_return_i = 1'b0;
		beats_seen = 0;
		credits_back = 0;
		stim_done = 1'b0;
		load_vectors();
		repeat (8) begin
			@(posedge clk);
			#1;
			assert (beat_valid_o === 1'b0) else begin
				abort_run("beat_valid_o was not low during reset");
			end
		end
		rst = 1'b0;
		@(negedge clk);
		assert (req_ready_o === 1'b1 && beat_valid_o === 1'b0) else begin
			abort_run("after reset req_ready_o was not high or beat_valid_o was not low");
		end
		fork
			return_credits();
		join_none
		fork
			send_requests();
			check_beats();
		join
		// nothing more may come out once the list is used up
		repeat (32) begin
			@(negedge clk);
			assert (beat_valid_o === 1'b0) else begin
				abort_run("an extra beat came out after the last expected beat");
			end
		end
		stim_done = 1'b1;
		if (u_dut.u_credit_port.u_sva.fail_cnt == 0) begin
			$display("Result: PASSED");
			$finish;
		end else begin
			abort_run("an assertion in the credit port checker failed");
		end
	end

endmodule

// File: test/fix_msg_builder_sva.sv
// FIX credit port assertions
`timescale 1ns/1ps
`include "fix_settings.svh"

module fix_msg_builder_sva #(
	parameter int CRED_W = $clog2(`FIX_TX_CREDITS + 1)
) (
	input logic              clk,
	input logic              rst,
	input logic              beat_valid_i,
	input logic              credit_return_i,
	input logic [CRED_W-1:0] credit_i,
	input logic [CRED_W-1:0] credit_avail_i
);

	// number of failed checks
	int fail_cnt = 0;

	// a wrapped counter would read above the buffer size
	a_outstanding_range: assert property (@(posedge clk) disable iff (rst)
		credit_i <= CRED_W'(`FIX_TX_CREDITS))
		else begin
			$error("outstanding beats exceed the consumer buffer");
			fail_cnt++;
		end

	a_quiet_in_reset: assert property (@(posedge clk)
		rst |=> !beat_valid_i)
		else begin
			$error("beat valid while in reset");
			fail_cnt++;
		end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst)
		credit_return_i |-> credit_avail_i < CRED_W'(`FIX_TX_CREDITS))
		else begin
			$error("credit return overflows the counter");
			fail_cnt++;
		end

endmodule

bind fix_credit_port fix_msg_builder_sva u_sva (
	.clk             (clk),
	.rst             (rst),
	.beat_valid_i    (beat_valid_o),
	.credit_return_i (credit_return_i),
	.credit_i        (credit_q),
	.credit_avail_i  (credit_avail)
);

// File: hdl/fix_msg_builder.sv
// FIX session message builder
`timescale 1ns/1ps

module fix_msg_builder (
	input  logic               clk,
	input  logic               rst,
	input  logic               req_valid_i,
	input  fix_pkg::fix_req_t  req_i,
	output logic               req_ready_o,
	output logic               beat_valid_o,
	output fix_pkg::fix_beat_t beat_o,
	input  logic               credit_return_i
);
	import fix_pkg::*;

	logic       fld_valid;
	fix_field_t fld;
	logic       fld_ready;

	// formatter to checksum
	logic       fmt_valid;
	fix_beat_t  fmt_beat;
	logic       fmt_ready;

	// checksum to credit port
	logic       chk_valid;
	fix_beat_t  chk_beat;
	logic       chk_ready;

	fix_field_sequencer u_sequencer (
		.clk         (clk),
		.rst         (rst),
		.req_valid_i (req_valid_i),
		.req_i       (req_i),
		.req_ready_o (req_ready_o),
		.fld_valid_o (fld_valid),
		.fld_o       (fld),
		.fld_ready_i (fld_ready)
	);

	fix_field_formatter u_formatter (
		.clk          (clk),
		.rst          (rst),
		.fld_valid_i  (fld_valid),
		.fld_i        (fld),
		.fld_ready_o  (fld_ready),
		.beat_valid_o (fmt_valid),
		.beat_o       (fmt_beat),
		.beat_ready_i (fmt_ready)
	);

	fix_checksum_stage u_checksum (
		.clk          (clk),
		.rst          (rst),
		.beat_valid_i (fmt_valid),
		.beat_i       (fmt_beat),
		.beat_ready_o (fmt_ready),
		.beat_valid_o (chk_valid),
		.beat_o       (chk_beat),
		.beat_ready_i (chk_ready)
	);

	fix_credit_port u_credit_port (
		.clk             (clk),
		.rst             (rst),
		.beat_valid_i    (chk_valid),
		.beat_i          (chk_beat),
		.beat_ready_o    (chk_ready),
		.beat_valid_o    (beat_valid_o),
		.beat_o          (beat_o),
		.credit_return_i (credit_return_i)
	);

endmodule

// File: hdl/fix_credit_port.sv
// FIX credit output port
`timescale 1ns/1ps
`include "fix_settings.svh"

module fix_credit_port (
	input  logic               clk,
	input  logic               rst,
	input  logic               beat_valid_i,
	input  fix_pkg::fix_beat_t beat_i,
	output logic               beat_ready_o,
	output logic               beat_valid_o,
	output fix_pkg::fix_beat_t beat_o,
	input  logic               credit_return_i
);
	import fix_pkg::*;

	localparam int CRED_W = $clog2(`FIX_TX_CREDITS + 1);

	logic [CRED_W-1:0] credit_q;
	logic [CRED_W-1:0] credit_avail;
	logic              beat_valid_q;
	fix_beat_t         beat_q;
	logic              in_xfer;

	// the beat now on the output already owns one credit
	assign credit_avail = credit_q - CRED_W'(beat_valid_q);
	assign beat_ready_o = (credit_avail != '0);
	assign in_xfer = beat_valid_i & beat_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			credit_q <= CRED_W'(`FIX_TX_CREDITS);
			beat_valid_q <= 1'b0;
		end else begin
			beat_valid_q <= in_xfer;
			credit_q <= credit_avail + CRED_W'(credit_return_i);
		end
	end

	always_ff @(posedge clk) begin
		if (in_xfer) begin
			beat_q <= beat_i;
		end
	end

	assign beat_valid_o = beat_valid_q;
	assign beat_o = beat_q;

endmodule

// File: hdl/fix_checksum_stage.sv
// FIX checksum stage
`timescale 1ns/1ps
`include "fix_settings.svh"

module fix_checksum_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               beat_valid_i,
	input  fix_pkg::fix_beat_t beat_i,
	output logic               beat_ready_o,
	output logic               beat_valid_o,
	output fix_pkg::fix_beat_t beat_o,
	input  logic               beat_ready_i
);
	import fix_pkg::*;

	localparam int SUM_W = $clog2(`FIX_CHKSUM_MOD);

	logic [SUM_W-1:0] sum_q;
	logic [SUM_W-1:0] sum_d;
	logic             beat_valid_q;
	fix_beat_t        beat_q;
	logic             in_xfer;

	// only the first len bytes of the selected view count
	function automatic int byte_sum(input fix_beat_t b);
		int s;
		s = 0;
		if (b.is_tag) begin
			for (int i = 0; i < `FIX_TAG_BYTES; i++) begin
				if (i < int'(b.payload.tag.len)) begin
					s = s + int'(b.payload.tag.text[i*8 +: 8]);
				end
			end
		end else begin
			for (int i = 0; i < `FIX_VAL_BYTES; i++) begin
				if (i < int'(b.payload.val.len)) begin
					s = s + int'(b.payload.val.text[i*8 +: 8]);
				end
			end
		end
		return s;
	endfunction

	// hundreds digit goes first
	function automatic fix_text_t sum_digits(input logic [SUM_W-1:0] s);
		fix_text_t t;
		t = '0;
		t[7:0] = 8'h30 + 8'(s / 100);
		t[15:8] = 8'h30 + 8'((s / 10) % 10);
		t[23:16] = 8'h30 + 8'(s % 10);
		return t;
	endfunction

	assign sum_d = SUM_W'((int'(sum_q) + byte_sum(beat_i)) % `FIX_CHKSUM_MOD);
	assign beat_ready_o = ~beat_valid_q | beat_ready_i;
	assign in_xfer = beat_valid_i & beat_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			beat_valid_q <= 1'b0;
			sum_q <= '0;
		end else begin
			if (beat_ready_o) begin
				beat_valid_q <= beat_valid_i;
			end
			if (in_xfer) begin
				sum_q <= beat_i.last ? '0 : sum_d;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_xfer) begin
			beat_q <= beat_i;
			if (beat_i.last) begin
				beat_q.payload.val.text <= sum_digits(sum_q);
			end
		end
	end

	assign beat_valid_o = beat_valid_q;
	assign beat_o = beat_q;

endmodule

// File: hdl/fix_field_formatter.sv
// FIX tag and value formatter
`timescale 1ns/1ps
`include "fix_settings.svh"

module fix_field_formatter (
	input  logic                clk,
	input  logic                rst,
	input  logic                fld_valid_i,
	input  fix_pkg::fix_field_t fld_i,
	output logic                fld_ready_o,
	output logic                beat_valid_o,
	output fix_pkg::fix_beat_t  beat_o,
	input  logic                beat_ready_i
);
	import fix_pkg::*;

	// set while the value beat of the held field is still owed
	logic       phase_q;
	fix_field_t fld_q;
	logic       beat_valid_q;
	fix_beat_t  beat_q;
	logic       out_free;
	logic       fld_xfer;

	// literal is right-aligned, result has the first char in byte 0
	function automatic fix_text_t ascii_text(input logic [63:0] s, input fix_len_t n);
		fix_text_t t;
		t = '0;
		for (int i = 0; i < `FIX_VAL_BYTES; i++) begin
			if (i < int'(n)) begin
				t[i*8 +: 8] = s[(int'(n) - 1 - i)*8 +: 8];
			end
		end
		return t;
	endfunction

	function automatic logic [7:0] msg_char(input fix_msg_type_e t);
		logic [7:0] c;
		case (t)
			MSG_LOGON:     c = "A";
			MSG_HEARTBEAT: c = "0";
			MSG_LOGOUT:    c = "5";
			default:       c = 8'h00;
		endcase
		return c;
	endfunction

	function automatic fix_beat_t tag_beat(input fix_field_e f);
		fix_beat_t   b;
		logic [35:0] tl;
		fix_text_t   t;
		// length in the top nibble, tag digits below
		case (f)
			FLD_BEGIN_STRING: tl = {4'd1, 32'("8")};
			FLD_MSG_SEQ_NUM:  tl = {4'd2, 32'("34")};
			FLD_MSG_TYPE:     tl = {4'd2, 32'("35")};
			FLD_SENDER:       tl = {4'd2, 32'("49")};
			FLD_TARGET:       tl = {4'd2, 32'("56")};
			FLD_ENCRYPT:      tl = {4'd2, 32'("98")};
			FLD_HEARTBT:      tl = {4'd3, 32'("108")};
			default:          tl = {4'd2, 32'("10")};
		endcase
		t = ascii_text(64'(tl[31:0]), tl[35:32]);
		b = '0;
		b.is_tag = 1'b1;
		b.payload.tag.len = tl[35:32];
		b.payload.tag.text = t[`FIX_TAG_BYTES*8-1:0];
		return b;
	endfunction

	function automatic fix_beat_t value_beat(input fix_field_t f);
		fix_beat_t b;
		b = '0;
		case (f.fld)
			FLD_BEGIN_STRING: b.payload.val = {4'd7, ascii_text("FIX.4.2", 4'd7)};
			FLD_MSG_TYPE:     b.payload.val = {4'd1, 56'h0, msg_char(f.req.msg_type)};
			FLD_SENDER:       b.payload.val = {f.req.sender_len, f.req.sender};
			FLD_TARGET:       b.payload.val = {f.req.target_len, f.req.target};
			FLD_ENCRYPT:      b.payload.val = {4'd1, 56'h0, "0"};
			FLD_HEARTBT:      b.payload.val = {f.req.hbt_len, f.req.hbt};
			FLD_MSG_SEQ_NUM: begin
				// leading zeros kept, most significant digit first
				b.payload.val.len = 4'(`FIX_SEQ_DIGITS);
				for (int d = 0; d < `FIX_SEQ_DIGITS; d++) begin
					b.payload.val.text[d*8 +: 8] = {4'h3, f.seq[(`FIX_SEQ_DIGITS-1-d)*4 +: 4]};
				end
			end
			default: begin
				// checksum digits are filled in downstream
				b.payload.val.len = 4'd3;
				b.last = 1'b1;
			end
		endcase
		return b;
	endfunction

	assign out_free = ~beat_valid_q | beat_ready_i;
	assign fld_ready_o = out_free & ~phase_q;
	assign fld_xfer = fld_valid_i & fld_ready_o;

	always_ff @(posedge clk) begin
		if (rst) begin
			phase_q <= 1'b0;
			beat_valid_q <= 1'b0;
		end else if (fld_xfer) begin
			phase_q <= 1'b1;
			beat_valid_q <= 1'b1;
		end else if (out_free) begin
			beat_valid_q <= phase_q;
			phase_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fld_xfer) begin
			fld_q <= fld_i;
			beat_q <= tag_beat(fld_i.fld);
		end else if (out_free && phase_q) begin
			beat_q <= value_beat(fld_q);
		end
	end

	assign beat_valid_o = beat_valid_q;
	assign beat_o = beat_q;

endmodule

// File: hdl/fix_field_sequencer.sv
// FIX field sequencer
`timescale 1ns/1ps
`include "fix_settings.svh"

module fix_field_sequencer (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid_i,
	input  fix_pkg::fix_req_t   req_i,
	output logic                req_ready_o,
	output logic                fld_valid_o,
	output fix_pkg::fix_field_t fld_o,
	input  logic                fld_ready_i
);
	import fix_pkg::*;

	localparam int SEQ_W = `FIX_SEQ_DIGITS * 4;

	logic             req_ready_q;
	logic             fld_valid_q;
	fix_field_e       cur_fld_q;
	fix_req_t         req_q;
	logic [SEQ_W-1:0] seq_q;
	logic             req_xfer;
	logic             fld_xfer;

	// BCD increment, all nines wrap to one
	function automatic logic [SEQ_W-1:0] bcd_inc(input logic [SEQ_W-1:0] v);
		logic [SEQ_W-1:0] r;
		logic             carry;
		r = v;
		carry = 1'b1;
		for (int d = 0; d < `FIX_SEQ_DIGITS; d++) begin
			if (carry) begin
				if (r[d*4 +: 4] == 4'd9) begin
					r[d*4 +: 4] = 4'd0;
				end else begin
					r[d*4 +: 4] = r[d*4 +: 4] + 4'd1;
					carry = 1'b0;
				end
			end
		end
		if (carry) begin
			r = SEQ_W'(1);
		end
		return r;
	endfunction

	// session fields only for logon
	function automatic fix_field_e next_fld(input fix_field_e f, input fix_msg_type_e t);
		fix_field_e n;
		case (f)
			FLD_BEGIN_STRING: n = FLD_MSG_SEQ_NUM;
			FLD_MSG_SEQ_NUM:  n = FLD_MSG_TYPE;
			FLD_MSG_TYPE:     n = FLD_SENDER;
			FLD_SENDER:       n = FLD_TARGET;
			FLD_ENCRYPT:      n = FLD_HEARTBT;
			FLD_HEARTBT:      n = FLD_CHECKSUM;
			FLD_TARGET: begin
				if (t == MSG_LOGON) begin
					n = FLD_ENCRYPT;
				end else begin
					n = FLD_CHECKSUM;
				end
			end
			default:          n = FLD_CHECKSUM;
		endcase
		return n;
	endfunction

	assign req_xfer = req_valid_i & req_ready_q;
	assign fld_xfer = fld_valid_q & fld_ready_i;

	always_ff @(posedge clk) begin
		if (rst) begin
			req_ready_q <= 1'b1;
			fld_valid_q <= 1'b0;
			cur_fld_q <= FLD_BEGIN_STRING;
			seq_q <= SEQ_W'(1);
		end else if (req_xfer) begin
			req_ready_q <= 1'b0;
			fld_valid_q <= 1'b1;
			cur_fld_q <= FLD_BEGIN_STRING;
		end else if (fld_xfer) begin
			if (cur_fld_q == FLD_CHECKSUM) begin
				// message done, open for the next request
				req_ready_q <= 1'b1;
				fld_valid_q <= 1'b0;
				seq_q <= bcd_inc(seq_q);
			end else begin
				cur_fld_q <= next_fld(cur_fld_q, req_q.msg_type);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (req_xfer) begin
			req_q <= req_i;
		end
	end

	assign req_ready_o = req_ready_q;
	assign fld_valid_o = fld_valid_q;
	assign fld_o = '{fld: cur_fld_q, req: req_q, seq: seq_q};

endmodule

// File: hdl/fix_pkg.sv
// FIX message builder types
`include "fix_settings.svh"

package fix_pkg;

	// one-hot message type codes
	typedef enum logic [3:0] {
		MSG_LOGON     = 4'b0001,
		MSG_HEARTBEAT = 4'b0010,
		MSG_LOGOUT    = 4'b0100
	} fix_msg_type_e;

	// fields in emission order
	typedef enum logic [3:0] {
		FLD_BEGIN_STRING = 4'd0,
		FLD_MSG_SEQ_NUM  = 4'd1,
		FLD_MSG_TYPE     = 4'd2,
		FLD_SENDER       = 4'd3,
		FLD_TARGET       = 4'd4,
		FLD_ENCRYPT      = 4'd5,
		FLD_HEARTBT      = 4'd6,
		FLD_CHECKSUM     = 4'd7
	} fix_field_e;

	// byte 0 is the first character
	typedef logic [`FIX_VAL_BYTES*8-1:0] fix_text_t;
	typedef logic [3:0] fix_len_t;

	typedef struct packed {
		fix_msg_type_e msg_type;
		fix_text_t     sender;
		fix_len_t      sender_len;
		fix_text_t     target;
		fix_len_t      target_len;
		fix_text_t     hbt;
		fix_len_t      hbt_len;
	} fix_req_t;

	typedef struct packed {
		fix_field_e                      fld;
		fix_req_t                        req;
		logic [`FIX_SEQ_DIGITS*4-1:0]    seq;
	} fix_field_t;

	// same word seen as a tag or as a value
	typedef union packed {
		struct packed {
			fix_len_t                                        len;
			logic [(`FIX_VAL_BYTES-`FIX_TAG_BYTES)*8-1:0]    rsvd;
			logic [`FIX_TAG_BYTES*8-1:0]                     text;
		} tag;
		struct packed {
			fix_len_t  len;
			fix_text_t text;
		} val;
	} fix_payload_u;

	typedef struct packed {
		logic         is_tag;
		logic         last;
		fix_payload_u payload;
	} fix_beat_t;

endpackage

// File: hdl/fix_settings.svh
// FIX builder settings
`ifndef FIX_SETTINGS_SVH
`define FIX_SETTINGS_SVH

// beats the consumer can buffer
`define FIX_TX_CREDITS 4

// value text width in bytes
`define FIX_VAL_BYTES 8

// tag text width in bytes
`define FIX_TAG_BYTES 4

// sequence number, decimal digits
`define FIX_SEQ_DIGITS 4

// checksum is the byte sum modulo this
`define FIX_CHKSUM_MOD 256
`endif
